/* design/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Word address widths of the two memories
`define CPU_IMEM_AW 10
`define CPU_DMEM_AW 10

// The one CSR the core implements, visible at the top ports
`define CPU_CSR_TOHOST 12'h51E

`endif

/* design/cpu_pkg.sv */
package cpu_pkg;

    // RV32I major opcodes used by the core
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {WB_LOAD, WB_ALU, WB_PC4} wb_sel_e;

    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;      // Also the CSR number for SYSTEM
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // One instruction word, seen through each encoding
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    localparam logic [31:0] NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

endpackage

/* design/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic        clk,
    input  logic        we,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    input  logic [4:0]  wa,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0)
            regs[wa] <= wd;
    end

    // x0 reads as zero regardless of array content
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

/* design/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen (
    input  cpu_pkg::inst_u    inst,
    input  cpu_pkg::imm_sel_e imm_sel,
    output logic [31:0]       imm
);

    always_comb begin
        case (imm_sel)
            cpu_pkg::IMM_S:
                imm = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5,
                       inst.s_fmt.imm_4_0};
            cpu_pkg::IMM_B:
                imm = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                       inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
            cpu_pkg::IMM_U:
                imm = {inst.u_fmt.imm_31_12, 12'd0};  // Upper 20 bits
            cpu_pkg::IMM_J:
                imm = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                       inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};
            default:
                imm = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
        endcase
    end

endmodule

/* design/exec_unit.sv */
`timescale 1ns/10ps

module exec_unit (
    input  logic [31:0]      op_a,
    input  logic [31:0]      op_b,
    input  logic [31:0]      rs1,
    input  logic [31:0]      rs2,
    input  cpu_pkg::alu_op_e alu_op,
    input  logic             br_un,
    input  logic [2:0]       funct3,
    input  logic             is_branch,
    output logic [31:0]      alu_out,
    output logic             br_taken
);

    logic [4:0] shamt;
    logic       br_eq, br_lt, cond;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            cpu_pkg::ALU_SUB:    alu_out = op_a - op_b;
            cpu_pkg::ALU_SLL:    alu_out = op_a << shamt;
            cpu_pkg::ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::ALU_SLTU:   alu_out = {31'd0, op_a < op_b};
            cpu_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            cpu_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            cpu_pkg::ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            cpu_pkg::ALU_OR:     alu_out = op_a | op_b;
            cpu_pkg::ALU_AND:    alu_out = op_a & op_b;
            cpu_pkg::ALU_PASS_B: alu_out = op_b;          // LUI
            default:             alu_out = op_a + op_b;
        endcase
    end

    // Branch comparator works on the forwarded register values
    assign br_eq = (rs1 == rs2);
    assign br_lt = br_un ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));

    // funct3[2] picks less-than over equal, funct3[0] inverts
    assign cond     = funct3[2] ? br_lt : br_eq;
    assign br_taken = is_branch && (cond ^ funct3[0]);

endmodule

/* design/mem_access.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module mem_access (
    input  logic               clk,
    input  logic               we,
    input  cpu_pkg::mem_size_e size,
    input  logic               ld_unsigned,
    input  logic [31:0]        addr,
    input  logic [31:0]        store_data,
    input  logic [1:0]         wb_offset,
    output logic [31:0]        load_data
);

    logic [31:0] mem [2**`CPU_DMEM_AW];
    logic [`CPU_DMEM_AW-1:0] word_idx;
    logic [31:0] wdata, rdata_q, rshift;
    logic [3:0]  be;
    cpu_pkg::mem_size_e size_q;
    logic        unsigned_q;

    assign word_idx = addr[`CPU_DMEM_AW+1:2];

    // Store lanes, replicated data plus shifted byte enables
    always_comb begin
        case (size)
            cpu_pkg::SIZE_BYTE: begin
                wdata = {4{store_data[7:0]}};
                be    = 4'b0001 << addr[1:0];
            end
            cpu_pkg::SIZE_HALF: begin
                wdata = {2{store_data[15:0]}};
                be    = 4'b0011 << addr[1:0];
            end
            default: begin
                wdata = store_data;
                be    = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we && be[i])
                mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
        rdata_q    <= mem[word_idx];  // Read every cycle, used only by loads
        size_q     <= size;
        unsigned_q <= ld_unsigned;
    end

    // WB side extraction
    assign rshift = rdata_q >> {wb_offset, 3'b000};

    always_comb begin
        case (size_q)
            cpu_pkg::SIZE_BYTE:
                load_data = {{24{!unsigned_q && rshift[7]}}, rshift[7:0]};
            cpu_pkg::SIZE_HALF:
                load_data = {{16{!unsigned_q && rshift[15]}}, rshift[15:0]};
            default:
                load_data = rdata_q;
        endcase
    end

endmodule

/* design/ctrl_unit.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module ctrl_unit (
    input  logic                run,
    input  cpu_pkg::inst_u      d_inst,
    input  cpu_pkg::inst_u      ex_inst,
    input  cpu_pkg::inst_u      wb_inst,
    input  logic                br_taken,
    output cpu_pkg::imm_sel_e   imm_sel,
    output logic                br_un,
    output logic                a_sel,
    output logic                b_sel,
    output cpu_pkg::alu_op_e    alu_op,
    output logic                mem_we,
    output cpu_pkg::mem_size_e  mem_size,
    output logic                ld_unsigned,
    output cpu_pkg::wb_sel_e    wb_sel,
    output logic                reg_we,
    output logic                csr_en,
    output logic                csr_imm,
    output logic                fwd_a_d,
    output logic                fwd_b_d,
    output logic                fwd_a_ex,
    output logic                fwd_b_ex,
    output logic                pc_redirect,
    output logic                inst_kill
);

    cpu_pkg::opcode_e ex_op, wb_op;
    logic [2:0]       ex_f3;
    logic [4:0]       wb_rd;
    logic             wb_fwd;

    assign ex_op = ex_inst.r_fmt.opcode;
    assign ex_f3 = ex_inst.r_fmt.funct3;
    assign wb_op = wb_inst.r_fmt.opcode;
    assign wb_rd = wb_inst.r_fmt.rd;

    // D stage
    always_comb begin
        case (d_inst.r_fmt.opcode)
            cpu_pkg::OP_STORE:                  imm_sel = cpu_pkg::IMM_S;
            cpu_pkg::OP_BRANCH:                 imm_sel = cpu_pkg::IMM_B;
            cpu_pkg::OP_LUI, cpu_pkg::OP_AUIPC: imm_sel = cpu_pkg::IMM_U;
            cpu_pkg::OP_JAL:                    imm_sel = cpu_pkg::IMM_J;
            default:                            imm_sel = cpu_pkg::IMM_I;
        endcase
    end

    // EX stage
    assign a_sel = (ex_op == cpu_pkg::OP_AUIPC) || (ex_op == cpu_pkg::OP_JAL) ||
                   (ex_op == cpu_pkg::OP_BRANCH);                // PC as operand A
    assign b_sel = (ex_op != cpu_pkg::OP_REG);
    assign br_un = ex_f3[1];                                     // BLTU, BGEU

    always_comb begin
        alu_op = cpu_pkg::ALU_ADD;  // Address and target adds
        if (ex_op == cpu_pkg::OP_LUI) begin
            alu_op = cpu_pkg::ALU_PASS_B;
        end else if (ex_op == cpu_pkg::OP_REG || ex_op == cpu_pkg::OP_IMM) begin
            case (ex_f3)
                3'b000: alu_op = (ex_op == cpu_pkg::OP_REG && ex_inst.r_fmt.funct7[5])
                                 ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
                3'b001: alu_op = cpu_pkg::ALU_SLL;
                3'b010: alu_op = cpu_pkg::ALU_SLT;
                3'b011: alu_op = cpu_pkg::ALU_SLTU;
                3'b100: alu_op = cpu_pkg::ALU_XOR;
                3'b101: alu_op = ex_inst.r_fmt.funct7[5] ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
                3'b110: alu_op = cpu_pkg::ALU_OR;
                default: alu_op = cpu_pkg::ALU_AND;
            endcase
        end
    end

    assign mem_we      = (ex_op == cpu_pkg::OP_STORE);
    assign mem_size    = cpu_pkg::mem_size_e'(ex_f3[1:0]);
    assign ld_unsigned = ex_f3[2];

    // CSRRW and CSRRWI to the tohost CSR only
    assign csr_en  = (ex_op == cpu_pkg::OP_SYSTEM) && (ex_f3[1:0] == 2'b01) &&
                     (ex_inst.i_fmt.imm == `CPU_CSR_TOHOST);
    assign csr_imm = ex_f3[2];

    assign pc_redirect = (ex_op == cpu_pkg::OP_JAL) || (ex_op == cpu_pkg::OP_JALR) || br_taken;
    assign inst_kill   = pc_redirect || !run;

    // WB stage
    always_comb begin
        case (wb_op)
            cpu_pkg::OP_LOAD:                  wb_sel = cpu_pkg::WB_LOAD;
            cpu_pkg::OP_JAL, cpu_pkg::OP_JALR: wb_sel = cpu_pkg::WB_PC4;
            default:                           wb_sel = cpu_pkg::WB_ALU;
        endcase
    end

    assign reg_we = (wb_op == cpu_pkg::OP_LUI) || (wb_op == cpu_pkg::OP_AUIPC) ||
                    (wb_op == cpu_pkg::OP_JAL) || (wb_op == cpu_pkg::OP_JALR) ||
                    (wb_op == cpu_pkg::OP_LOAD) || (wb_op == cpu_pkg::OP_IMM) ||
                    (wb_op == cpu_pkg::OP_REG);

    // Forwarding from WB, x0 never forwards
    assign wb_fwd   = reg_we && (wb_rd != 5'd0);
    assign fwd_a_d  = wb_fwd && (wb_rd == d_inst.r_fmt.rs1);
    assign fwd_b_d  = wb_fwd && (wb_rd == d_inst.r_fmt.rs2);
    assign fwd_a_ex = wb_fwd && (wb_rd == ex_inst.r_fmt.rs1);
    assign fwd_b_ex = wb_fwd && (wb_rd == ex_inst.r_fmt.rs2);

endmodule

/* design/cpu_top.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    imem_wen,
    input  logic [`CPU_IMEM_AW-1:0] imem_waddr,
    input  logic [31:0]             imem_wdata,
    output logic                    csr_wen,
    output logic [31:0]             csr_tohost
);

    logic [31:0] imem [2**`CPU_IMEM_AW];
    logic [31:0] imem_q;
    logic [31:0] pc, next_pc, d_pc4;
    logic [31:0] rd1, rd2, d_rs1, d_rs2, d_imm;
    logic [31:0] ex_pc, ex_pc4, ex_rs1, ex_rs2, ex_imm;
    logic [31:0] ex_a, ex_b, op_a, op_b, alu_out, csr_wdata;
    logic [31:0] wb_alu, wb_pc4, load_data, wb_data;
    logic        ex_is_branch, br_taken;
    cpu_pkg::inst_u d_inst, ex_inst, wb_inst;

    cpu_pkg::imm_sel_e  imm_sel;
    cpu_pkg::alu_op_e   alu_op;
    cpu_pkg::mem_size_e mem_size;
    cpu_pkg::wb_sel_e   wb_sel;
    logic br_un, a_sel, b_sel, mem_we, ld_unsigned, reg_we, csr_en, csr_imm;
    logic fwd_a_d, fwd_b_d, fwd_a_ex, fwd_b_ex, pc_redirect, inst_kill;

    ctrl_unit u_ctrl (
        .run(run), .d_inst(d_inst), .ex_inst(ex_inst), .wb_inst(wb_inst),
        .br_taken(br_taken), .imm_sel(imm_sel), .br_un(br_un), .a_sel(a_sel),
        .b_sel(b_sel), .alu_op(alu_op), .mem_we(mem_we), .mem_size(mem_size),
        .ld_unsigned(ld_unsigned), .wb_sel(wb_sel), .reg_we(reg_we),
        .csr_en(csr_en), .csr_imm(csr_imm), .fwd_a_d(fwd_a_d), .fwd_b_d(fwd_b_d),
        .fwd_a_ex(fwd_a_ex), .fwd_b_ex(fwd_b_ex), .pc_redirect(pc_redirect),
        .inst_kill(inst_kill)
    );

    // Fetch: the read address is next_pc so the word lines up with pc
    always_comb begin
        if (pc_redirect)
            next_pc = {alu_out[31:1], 1'b0};  // JALR drops bit 0
        else if (!run)
            next_pc = pc;
        else
            next_pc = pc + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= `CPU_RESET_PC;
        else
            pc <= next_pc;
    end

    always_ff @(posedge clk) begin
        if (imem_wen)
            imem[imem_waddr] <= imem_wdata;  // Load port
        imem_q <= imem[next_pc[`CPU_IMEM_AW+1:2]];
    end

    assign d_inst = cpu_pkg::inst_u'(imem_q);
    assign d_pc4  = pc + 32'd4;

    reg_file u_rf (
        .clk(clk), .we(reg_we), .ra1(d_inst.r_fmt.rs1), .ra2(d_inst.r_fmt.rs2),
        .wa(wb_inst.r_fmt.rd), .wd(wb_data), .rd1(rd1), .rd2(rd2)
    );

    imm_gen u_imm (.inst(d_inst), .imm_sel(imm_sel), .imm(d_imm));

    assign d_rs1 = fwd_a_d ? wb_data : rd1;  // WB result written this same edge
    assign d_rs2 = fwd_b_d ? wb_data : rd2;

    // D/EX registers
    always_ff @(posedge clk) begin
        if (rst)
            ex_inst <= cpu_pkg::inst_u'(cpu_pkg::NOP_INST);
        else
            ex_inst <= inst_kill ? cpu_pkg::inst_u'(cpu_pkg::NOP_INST) : d_inst;
    end

    always_ff @(posedge clk) begin
        ex_pc  <= pc;
        ex_pc4 <= d_pc4;
        ex_rs1 <= d_rs1;
        ex_rs2 <= d_rs2;
        ex_imm <= d_imm;
    end

    // EX stage
    assign ex_a = fwd_a_ex ? wb_data : ex_rs1;
    assign ex_b = fwd_b_ex ? wb_data : ex_rs2;
    assign op_a = a_sel ? ex_pc : ex_a;
    assign op_b = b_sel ? ex_imm : ex_b;
    assign ex_is_branch = (ex_inst.b_fmt.opcode == cpu_pkg::OP_BRANCH);

    exec_unit u_exec (
        .op_a(op_a), .op_b(op_b), .rs1(ex_a), .rs2(ex_b), .alu_op(alu_op),
        .br_un(br_un), .funct3(ex_inst.r_fmt.funct3), .is_branch(ex_is_branch),
        .alu_out(alu_out), .br_taken(br_taken)
    );

    mem_access u_mem (
        .clk(clk), .we(mem_we), .size(mem_size), .ld_unsigned(ld_unsigned),
        .addr(alu_out), .store_data(ex_b), .wb_offset(wb_alu[1:0]),
        .load_data(load_data)
    );

    assign csr_wdata = csr_imm ? {27'd0, ex_inst.r_fmt.rs1} : ex_a;  // uimm sits in rs1
    assign csr_wen   = csr_en;

    always_ff @(posedge clk) begin
        if (rst)
            csr_tohost <= 32'd0;
        else if (csr_en)
            csr_tohost <= csr_wdata;
    end

    // EX/WB registers
    always_ff @(posedge clk) begin
        if (rst)
            wb_inst <= cpu_pkg::inst_u'(cpu_pkg::NOP_INST);
        else
            wb_inst <= ex_inst;
    end

    always_ff @(posedge clk) begin
        wb_alu <= alu_out;
        wb_pc4 <= ex_pc4;
    end

    always_comb begin
        case (wb_sel)
            cpu_pkg::WB_LOAD: wb_data = load_data;
            cpu_pkg::WB_PC4:  wb_data = wb_pc4;
            default:          wb_data = wb_alu;
        endcase
    end

endmodule

/* tb/cpu_checker.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        csr_wen,
    input  logic [31:0] csr_tohost,
    input  logic [31:0] golden [2**`CPU_IMEM_AW],
    output int          writes,
    output int          mismatches,
    output int          extras
);

    logic        pending;  // A CSR write ended at the last rising edge
    logic [31:0] expected;

    initial begin
        writes     = 0;
        mismatches = 0;
        extras     = 0;
        pending    = 1'b0;
    end

    // Sampled at the falling edge, away from the DUT updates
    always @(negedge clk) begin
        if (pending) begin
            if (writes >= golden[1]) begin
                extras++;
                $display("Unexpected CSR write number %0d at %0t with value %h, only %0d expected",
                         writes + 1, $time, csr_tohost, golden[1]);
            end else begin
                // Expected values follow the program words
                expected = golden[2 + golden[0] + writes];
                if (csr_tohost !== expected) begin
                    mismatches++;
                    $display("[FAIL] %0t: CSR write %0d expected %h, got %h",
                             $time, writes + 1, expected, csr_tohost);
                end
            end
            writes++;
        end
        pending = !rst && (csr_wen === 1'b1);
    end

endmodule

/* tb/tb_cpu.sv */
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu;

    logic                    clk;
    logic                    rst;
    logic                    run;
    logic                    imem_wen;
    logic [`CPU_IMEM_AW-1:0] imem_waddr;
    logic [31:0]             imem_wdata;
    logic                    csr_wen;
    logic [31:0]             csr_tohost;
    logic [31:0]             golden [2**`CPU_IMEM_AW];  // Header, program, expected CSR values
    int                      writes;
    int                      mismatches;
    int                      extras;
    int                      missing;
    logic                    bad_file;

    cpu_top DUT (
        .clk(clk), .rst(rst), .run(run), .imem_wen(imem_wen), .imem_waddr(imem_waddr),
        .imem_wdata(imem_wdata), .csr_wen(csr_wen), .csr_tohost(csr_tohost)
    );

    cpu_checker u_checker (
        .clk(clk), .rst(rst), .csr_wen(csr_wen), .csr_tohost(csr_tohost),
        .golden(golden), .writes(writes), .mismatches(mismatches), .extras(extras)
    );

    always #20 clk = ~clk;  // 40 ns period

    // One word per cycle through the load port, core held by run
    task automatic load_program(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            imem_wen   <= 1'b1;
            imem_waddr <= i[`CPU_IMEM_AW-1:0];
            imem_wdata <= golden[2 + i];
        end
        @(posedge clk);
        imem_wen <= 1'b0;
    endtask

    initial begin
        int n;
        int m;
        int limit;
        int cycles;
        clk        = 1'b0;
        rst        = 1'b1;
        run        = 1'b0;
        imem_wen   = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        missing    = 0;
        bad_file   = 1'b0;
        $readmemh("tb/cpu_golden.mem", golden);
        if ($isunknown(golden[0]) || $isunknown(golden[1]) || golden[0] == 32'd0) begin
            bad_file = 1'b1;
            $display("Golden file tb/cpu_golden.mem is missing or has no program");
        end
        n = golden[0];
        m = golden[1];
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        if (!bad_file) begin
            load_program(n);
            @(posedge clk);
            run <= 1'b1;
            // Wait for all expected writes, bounded by the program length
            limit  = 20 * n + 200;
            cycles = 0;
            while (writes < m && cycles < limit) begin
                @(posedge clk);
                cycles++;
            end
            if (writes < m) begin
                missing = m - writes;
                $display("Timeout after %0d cycles: %0d of %0d CSR writes never arrived",
                         cycles, missing, m);
            end else begin
                repeat (20) @(posedge clk);  // Room for any stray write to show up
            end
        end
        $display("Errors: %0d mismatches, %0d extra writes, %0d missing writes",
                 mismatches, extras, missing);
        if (!bad_file && mismatches == 0 && extras == 0 && missing == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* tb/cpu_golden.mem */
// Word 0 is the program length N, word 1 the count M of expected CSR writes
// Then N instruction words from address 0 and M expected CSR values in order
00000031
0000000D
FFB00093  // 00 addi   x1, x0, -5
12345137  // 04 lui    x2, 0x12345
002081B3  // 08 add    x3, x1, x2
51E19073  // 0C csrrw  x0, 0x51E, x3
4010D213  // 10 srai   x4, x1, 1
01C0D293  // 14 srli   x5, x1, 28
00524333  // 18 xor    x6, x4, x5
51E31073  // 1C csrrw  x0, 0x51E, x6
0050A3B3  // 20 slt    x7, x1, x5
0050B433  // 24 sltu   x8, x1, x5
00439493  // 28 slli   x9, x7, 4
0084E533  // 2C or     x10, x9, x8
51E51073  // 30 csrrw  x0, 0x51E, x10
00001597  // 34 auipc  x11, 1
40258633  // 38 sub    x12, x11, x2
51E61073  // 3C csrrw  x0, 0x51E, x12
51EAD073  // 40 csrrwi x0, 0x51E, 21
00108463  // 44 beq    x1, x1, +8 taken
51EFD073  // 48 csrrwi x0, 0x51E, 31 killed
00109463  // 4C bne    x1, x1, +8 not taken
51E0D073  // 50 csrrwi x0, 0x51E, 1
0050C463  // 54 blt    x1, x5, +8 taken
51EFD073  // 58 csrrwi x0, 0x51E, 31 killed
0050E463  // 5C bltu   x1, x5, +8 not taken
51E15073  // 60 csrrwi x0, 0x51E, 2
0012D463  // 64 bge    x5, x1, +8 taken
51EFD073  // 68 csrrwi x0, 0x51E, 31 killed
0012F463  // 6C bgeu   x5, x1, +8 not taken
51E1D073  // 70 csrrwi x0, 0x51E, 3
008006EF  // 74 jal    x13, +8
51EFD073  // 78 csrrwi x0, 0x51E, 31 killed
00C68767  // 7C jalr   x14, 12(x13)
51EFD073  // 80 csrrwi x0, 0x51E, 31 killed
00E687B3  // 84 add    x15, x13, x14
51E79073  // 88 csrrw  x0, 0x51E, x15
10C02023  // 8C sw     x12, 0x100(x0)
105000A3  // 90 sb     x5, 0x101(x0)
10101123  // 94 sh     x1, 0x102(x0)
10201803  // 98 lh     x16, 0x102(x0)
51E81073  // 9C csrrw  x0, 0x51E, x16 uses the load right away
10304883  // A0 lbu    x17, 0x103(x0)
10000903  // A4 lb     x18, 0x100(x0)
012889B3  // A8 add    x19, x17, x18
51E99073  // AC csrrw  x0, 0x51E, x19
10002A03  // B0 lw     x20, 0x100(x0)
51EA1073  // B4 csrrw  x0, 0x51E, x20
00700013  // B8 addi   x0, x0, 7 ignored
51E01073  // BC csrrw  x0, 0x51E, x0
0000006F  // C0 jal    x0, 0 spins here
12344FFB  // x3
FFFFFFF2  // x6
00000010  // x10
EDCBC034  // x12
00000015  // uimm 21
00000001
00000002
00000003
000000F8  // x13 + x14
FFFFFFFB  // lh sign extended
00000133  // lbu plus lb
FFFB0F34  // lw of the merged word
00000000  // x0

/* flist.f */
+incdir+design
design/cpu_pkg.sv
design/reg_file.sv
design/imm_gen.sv
design/exec_unit.sv
design/mem_access.sv
design/ctrl_unit.sv
design/cpu_top.sv
tb/cpu_checker.sv
tb/tb_cpu.sv
